// File: source/pcu_pkg.sv
// Shared constants for the performance counter unit.
// Address map assumes the SPR layout with the group in bits 15:11.
// At most eight counter slots fit the map, PCCR at 0..7 and PCMR at 8..15.
// PCMR bits 14 to 31 are reserved and always read zero.

`default_nettype none

package pcu_pkg;

  // SPR group of the unit and the field that holds it
  localparam logic [4:0] SPR_GROUP_PCU = 5'd7;
  localparam int SPR_GROUP_LSB = 11;
  localparam int SPR_OFFSET_W = 11;

  // PCCR n sits at offset n, PCMR n at PCMR_OFFSET + n
  localparam int PCMR_OFFSET = 8;
  localparam int MAX_COUNTERS = 8;

  // Pipeline events
  localparam int NUM_EVENTS = 11;

  typedef logic [NUM_EVENTS-1:0] event_vec_t;

  // Bit positions inside event_vec_t, also the order of the PCMR enables
  localparam int EVT_LOAD = 0;
  localparam int EVT_STORE = 1;
  localparam int EVT_IFETCH = 2;
  localparam int EVT_DCACHE_MISS = 3;
  localparam int EVT_ICACHE_MISS = 4;
  localparam int EVT_IFETCH_STALL = 5;
  localparam int EVT_LSU_STALL = 6;
  localparam int EVT_BRN_STALL = 7;
  localparam int EVT_DTLB_MISS = 8;
  localparam int EVT_ITLB_MISS = 9;
  localparam int EVT_DATADEP_STALL = 10;

  // PCMR fields
  localparam int PCMR_CP = 0;
  localparam int PCMR_CISM = 1;
  localparam int PCMR_CIUM = 2;
  // Event enables occupy bits 3..13
  localparam int PCMR_EVT_LSB = 3;

  // Bits 1..13 can be written, CP is fixed
  localparam logic [31:0] PCMR_WRITE_MASK = 32'h0000_3FFE;

  // Counter present, nothing enabled
  localparam logic [31:0] PCMR_RESET = 32'h0000_0001 << PCMR_CP;

endpackage

`default_nettype wire

// File: source/pcu_event_count.sv
// Counts enabled events that are active in one cycle.
// Simultaneous events all count, result is 0 to NUM_EVENTS.

`timescale 1ns/1ps
`default_nettype none

module pcu_event_count (
  input  pcu_pkg::event_vec_t events_i,
  input  pcu_pkg::event_vec_t enable_mask_i,
  output logic [3:0]          count_o
);

  pcu_pkg::event_vec_t active;

  assign active = events_i & enable_mask_i;

  // Population count of the masked vector
  always_comb begin
    count_o = '0;
    for (int i = 0; i < pcu_pkg::NUM_EVENTS; i++) begin
      count_o = count_o + 4'(active[i]);
    end
  end

endmodule

`default_nettype wire

// File: source/pcu_counter_slot.sv
// One counter slot, a PCCR count register and its PCMR mode register.
// Count wraps at 2^32, no overflow indication.
// A PCCR write wins over the increment of the same cycle.
// A PCMR write takes effect from the next cycle.

`timescale 1ns/1ps
`default_nettype none

module pcu_counter_slot (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          pccr_we_i,
  input  wire logic          pcmr_we_i,
  input  wire logic [31:0]   wr_dat_i,
  input  wire logic          spr_sys_mode_i,
  input  pcu_pkg::event_vec_t events_i,
  output logic [31:0]        pccr_o,
  output logic [31:0]        pcmr_o
);

  logic [31:0]         pccr_q;
  logic [31:0]         pcmr_q;
  pcu_pkg::event_vec_t enable_mask;
  logic [3:0]          evt_count;
  logic                count_en;

  // Event enables straight out of the mode register
  assign enable_mask = pcmr_q[pcu_pkg::PCMR_EVT_LSB +: pcu_pkg::NUM_EVENTS];

  pcu_event_count u_event_count (
    .events_i      (events_i),
    .enable_mask_i (enable_mask),
    .count_o       (evt_count)
  );

  // Privilege filter
  assign count_en = (pcmr_q[pcu_pkg::PCMR_CISM] && spr_sys_mode_i) ||
                    (pcmr_q[pcu_pkg::PCMR_CIUM] && !spr_sys_mode_i);

  // Mode register
  always_ff @(posedge clk) begin
    if (rst) begin
      pcmr_q <= pcu_pkg::PCMR_RESET;
    end else if (pcmr_we_i) begin
      // Reserved bits drop, CP stays set
      pcmr_q <= (wr_dat_i & pcu_pkg::PCMR_WRITE_MASK) | pcu_pkg::PCMR_RESET;
    end
  end

  // Count register
  always_ff @(posedge clk) begin
    if (rst) begin
      pccr_q <= '0;
    end else if (pccr_we_i) begin
      pccr_q <= wr_dat_i;
    end else if (count_en) begin
      // Natural 32-bit wrap
      pccr_q <= pccr_q + {28'd0, evt_count};
    end
  end

  assign pccr_o = pccr_q;
  assign pcmr_o = pcmr_q;

endmodule

`default_nettype wire

// File: source/pcu_spr_port.sv
// SPR access decoder for the performance counter unit.
// Acknowledges in the same cycle as the access, without back-pressure.
// Any group 7 access is acknowledged, even to unused offsets.
// Writes and PCMR reads need supervisor mode.

`timescale 1ns/1ps
`default_nettype none

module pcu_spr_port #(
  parameter int NUM_COUNTERS = 8
) (
  input  wire logic        spr_access_i,
  input  wire logic        spr_we_i,
  input  wire logic        spr_re_i,
  input  wire logic [15:0] spr_addr_i,
  input  wire logic [31:0] spr_dat_i,
  input  wire logic        spr_sys_mode_i,
  input  wire logic [pcu_pkg::MAX_COUNTERS*32-1:0] slot_pccr_i,
  input  wire logic [pcu_pkg::MAX_COUNTERS*32-1:0] slot_pcmr_i,
  output logic             spr_ack_o,
  output logic [31:0]      spr_dat_o,
  output logic [pcu_pkg::MAX_COUNTERS-1:0] pccr_we_o,
  output logic [pcu_pkg::MAX_COUNTERS-1:0] pcmr_we_o,
  output logic [31:0]      wr_dat_o
);

  localparam int IDX_W = $clog2(pcu_pkg::MAX_COUNTERS);
  localparam int OFS_W = pcu_pkg::SPR_OFFSET_W;

  logic             group_hit;
  logic [OFS_W-1:0] spr_offset;
  logic             pccr_hit;
  logic             pcmr_hit;
  logic [IDX_W-1:0] slot_idx;
  logic             slot_valid;
  logic             wr_ok;
  logic             rd_ok;

  assign spr_offset = spr_addr_i[OFS_W-1:0];
  assign group_hit  = spr_access_i &&
                      (spr_addr_i[15:pcu_pkg::SPR_GROUP_LSB] == pcu_pkg::SPR_GROUP_PCU);

  // Register kind from the offset range
  assign pccr_hit = spr_offset < OFS_W'(pcu_pkg::MAX_COUNTERS);
  assign pcmr_hit = (spr_offset >= OFS_W'(pcu_pkg::PCMR_OFFSET)) &&
                    (spr_offset < OFS_W'(pcu_pkg::PCMR_OFFSET + pcu_pkg::MAX_COUNTERS));

  // Low offset bits name the slot for PCCR and PCMR alike
  assign slot_idx   = spr_offset[IDX_W-1:0];
  // Slots the top level did not build
  assign slot_valid = int'(slot_idx) < NUM_COUNTERS;

  assign spr_ack_o = group_hit;

  assign wr_ok = group_hit && spr_we_i && spr_sys_mode_i && slot_valid;
  assign rd_ok = group_hit && spr_re_i && slot_valid;

  // One-hot write enables per slot
  always_comb begin
    pccr_we_o = '0;
    pcmr_we_o = '0;
    if (wr_ok && pccr_hit) begin
      pccr_we_o[slot_idx] = 1'b1;
    end
    if (wr_ok && pcmr_hit) begin
      pcmr_we_o[slot_idx] = 1'b1;
    end
  end

  assign wr_dat_o = spr_dat_i;

  // Read mux, zero for anything not readable
  always_comb begin
    spr_dat_o = '0;
    if (rd_ok) begin
      if (pccr_hit) begin
        spr_dat_o = slot_pccr_i[slot_idx*32 +: 32];
      end else if (pcmr_hit && spr_sys_mode_i) begin
        // Mode registers hidden from user code
        spr_dat_o = slot_pcmr_i[slot_idx*32 +: 32];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/pcu_top.sv
// Performance counter unit top level.
// NUM_COUNTERS may be 1 to 8; slots above it read zero and ignore writes.
// SPR accesses are acknowledged in the access cycle, reads are combinational.
// Events are sampled at every rising edge of clk.

`timescale 1ns/1ps
`default_nettype none

module pcu_top #(
  parameter int NUM_COUNTERS = 8
) (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        spr_access_i,
  input  wire logic        spr_we_i,
  input  wire logic        spr_re_i,
  input  wire logic [15:0] spr_addr_i,
  input  wire logic [31:0] spr_dat_i,
  output logic             spr_ack_o,
  output logic [31:0]      spr_dat_o,
  input  wire logic        spr_sys_mode_i,
  input  wire logic        evt_load_i,
  input  wire logic        evt_store_i,
  input  wire logic        evt_ifetch_i,
  input  wire logic        evt_dcache_miss_i,
  input  wire logic        evt_icache_miss_i,
  input  wire logic        evt_ifetch_stall_i,
  input  wire logic        evt_lsu_stall_i,
  input  wire logic        evt_brn_stall_i,
  input  wire logic        evt_dtlb_miss_i,
  input  wire logic        evt_itlb_miss_i,
  input  wire logic        evt_datadep_stall_i
);

  localparam int NSLOT = pcu_pkg::MAX_COUNTERS;

  pcu_pkg::event_vec_t   events;
  logic [NSLOT-1:0]      pccr_we;
  logic [NSLOT-1:0]      pcmr_we;
  logic [31:0]           wr_dat;
  logic [NSLOT*32-1:0]   slot_pccr;
  logic [NSLOT*32-1:0]   slot_pcmr;

  // Event vector in PCMR enable order
  assign events[pcu_pkg::EVT_LOAD]          = evt_load_i;
  assign events[pcu_pkg::EVT_STORE]         = evt_store_i;
  assign events[pcu_pkg::EVT_IFETCH]        = evt_ifetch_i;
  assign events[pcu_pkg::EVT_DCACHE_MISS]   = evt_dcache_miss_i;
  assign events[pcu_pkg::EVT_ICACHE_MISS]   = evt_icache_miss_i;
  assign events[pcu_pkg::EVT_IFETCH_STALL]  = evt_ifetch_stall_i;
  assign events[pcu_pkg::EVT_LSU_STALL]     = evt_lsu_stall_i;
  assign events[pcu_pkg::EVT_BRN_STALL]     = evt_brn_stall_i;
  assign events[pcu_pkg::EVT_DTLB_MISS]     = evt_dtlb_miss_i;
  assign events[pcu_pkg::EVT_ITLB_MISS]     = evt_itlb_miss_i;
  assign events[pcu_pkg::EVT_DATADEP_STALL] = evt_datadep_stall_i;

  pcu_spr_port #(
    .NUM_COUNTERS (NUM_COUNTERS)
  ) u_spr_port (
    .spr_access_i   (spr_access_i),
    .spr_we_i       (spr_we_i),
    .spr_re_i       (spr_re_i),
    .spr_addr_i     (spr_addr_i),
    .spr_dat_i      (spr_dat_i),
    .spr_sys_mode_i (spr_sys_mode_i),
    .slot_pccr_i    (slot_pccr),
    .slot_pcmr_i    (slot_pcmr),
    .spr_ack_o      (spr_ack_o),
    .spr_dat_o      (spr_dat_o),
    .pccr_we_o      (pccr_we),
    .pcmr_we_o      (pcmr_we),
    .wr_dat_o       (wr_dat)
  );

  for (genvar i = 0; i < NSLOT; i++) begin : g_slot
    if (i < NUM_COUNTERS) begin : g_used
      pcu_counter_slot u_slot (
        .clk            (clk),
        .rst            (rst),
        .pccr_we_i      (pccr_we[i]),
        .pcmr_we_i      (pcmr_we[i]),
        .wr_dat_i       (wr_dat),
        .spr_sys_mode_i (spr_sys_mode_i),
        .events_i       (events),
        .pccr_o         (slot_pccr[i*32 +: 32]),
        .pcmr_o         (slot_pcmr[i*32 +: 32])
      );
    end else begin : g_absent
      // Not built, the port never selects these
      assign slot_pccr[i*32 +: 32] = '0;
      assign slot_pcmr[i*32 +: 32] = '0;
    end
  end

endmodule

`default_nettype wire

// File: tb/pcu_tb_tasks.svh
// SPR access tasks, reference model and random source for pcu_tb.
// Included inside the pcu_tb module, relies on its signals and NUM_SLOTS.
// Every access task starts on a falling edge and returns on the next one.

localparam int ACK_POLL = 2;

logic [31:0] exp_pccr [0:pcu_pkg::MAX_COUNTERS-1];
logic [31:0] exp_pcmr [0:pcu_pkg::MAX_COUNTERS-1];
logic [31:0] lcg_state;

// Plain LCG, callers take the upper bits
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

function automatic logic [15:0] pccr_addr(input int slot);
  return {pcu_pkg::SPR_GROUP_PCU, 11'(slot)};
endfunction

function automatic logic [15:0] pcmr_addr(input int slot);
  return {pcu_pkg::SPR_GROUP_PCU, 11'(pcu_pkg::PCMR_OFFSET + slot)};
endfunction

// Number of events both active and enabled
function automatic int active_count(input logic [10:0] ev, input logic [10:0] en);
  int n;
  n = 0;
  for (int i = 0; i < pcu_pkg::NUM_EVENTS; i++) begin
    if (ev[i] && en[i]) begin
      n++;
    end
  end
  return n;
endfunction

// Value a group 7 read should return before this cycle's edge
function automatic logic [31:0] expected_read(input logic [15:0] addr, input logic sys);
  int ofs;
  ofs = int'(addr[10:0]);
  if (ofs < NUM_SLOTS) begin
    return exp_pccr[ofs];
  end
  if (ofs >= pcu_pkg::PCMR_OFFSET && ofs < pcu_pkg::PCMR_OFFSET + NUM_SLOTS && sys) begin
    return exp_pcmr[ofs - pcu_pkg::PCMR_OFFSET];
  end
  return 32'h0;
endfunction

// What each built slot does at the rising edge
task automatic model_update(input logic wr, input logic [15:0] addr,
                            input logic [31:0] wdat, input logic sys,
                            input logic [10:0] ev);
  int ofs;
  logic on;
  ofs = int'(addr[10:0]);
  for (int i = 0; i < NUM_SLOTS; i++) begin
    on = (exp_pcmr[i][pcu_pkg::PCMR_CISM] && sys) ||
         (exp_pcmr[i][pcu_pkg::PCMR_CIUM] && !sys);
    if (wr && ofs == i) begin
      exp_pccr[i] = wdat;
    end else if (on) begin
      exp_pccr[i] = exp_pccr[i] +
                    32'(active_count(ev, exp_pcmr[i][pcu_pkg::PCMR_EVT_LSB +: 11]));
    end
    if (wr && ofs == pcu_pkg::PCMR_OFFSET + i) begin
      exp_pcmr[i] = (wdat & pcu_pkg::PCMR_WRITE_MASK) | pcu_pkg::PCMR_RESET;
    end
  end
endtask

task automatic drive_events(input logic [10:0] ev);
  evt_load_i          = ev[0];
  evt_store_i         = ev[1];
  evt_ifetch_i        = ev[2];
  evt_dcache_miss_i   = ev[3];
  evt_icache_miss_i   = ev[4];
  evt_ifetch_stall_i  = ev[5];
  evt_lsu_stall_i     = ev[6];
  evt_brn_stall_i     = ev[7];
  evt_dtlb_miss_i     = ev[8];
  evt_itlb_miss_i     = ev[9];
  evt_datadep_stall_i = ev[10];
endtask

// One bus cycle with checks, then the model steps over the rising edge
task automatic run_cycle(input logic acc, input logic we, input logic re,
                         input logic [15:0] addr, input logic [31:0] wdat,
                         input logic sys, input logic [10:0] ev);
  logic hit;
  logic [31:0] exp_dat;
  int polls;
  hit = acc && (addr[15:11] == pcu_pkg::SPR_GROUP_PCU);
  exp_dat = (hit && re) ? expected_read(addr, sys) : 32'h0;
  spr_access_i   = acc;
  spr_we_i       = we;
  spr_re_i       = re;
  spr_addr_i     = addr;
  spr_dat_i      = wdat;
  spr_sys_mode_i = sys;
  drive_events(ev);
  polls = 0;
  #1;
  // Ack is combinational, so it must show well before the rising edge
  while (hit && spr_ack_o !== 1'b1 && polls < ACK_POLL) begin
    #1;
    polls++;
  end
  if (hit && spr_ack_o !== 1'b1) begin
    abort_run("timeout: no acknowledge for a group 7 access");
  end else begin
    check_outputs(hit, exp_dat);
    model_update(hit && we && sys, addr, wdat, sys, ev);
    @(negedge clk);
  end
endtask

task automatic spr_write(input logic [15:0] addr, input logic [31:0] data, input logic sys);
  run_cycle(1'b1, 1'b1, 1'b0, addr, data, sys, 11'h0);
endtask

task automatic spr_read(input logic [15:0] addr, input logic sys);
  run_cycle(1'b1, 1'b0, 1'b1, addr, 32'h0, sys, 11'h0);
endtask

task automatic idle_cycle(input logic sys, input logic [10:0] ev);
  run_cycle(1'b0, 1'b0, 1'b0, 16'h0, 32'h0, sys, ev);
endtask

// File: tb/pcu_tb.sv
// Testbench for pcu_top with six counter slots built.
// Inputs change on the falling edge, outputs are checked 1 to 3 ns later.
// Expected values come from a cycle model of the counter rules.

`timescale 1ns/1ps
`default_nettype none

module pcu_tb;

  localparam int NUM_SLOTS = 6;
  localparam int RESET_CYCLES = 4;
  localparam int RANDOM_ROUNDS = 4;
  localparam int ROUND_CYCLES = 120;
  localparam int WATCHDOG_NS = 30000;

  logic        clk;
  logic        rst;
  logic        spr_access_i;
  logic        spr_we_i;
  logic        spr_re_i;
  logic [15:0] spr_addr_i;
  logic [31:0] spr_dat_i;
  logic        spr_ack_o;
  logic [31:0] spr_dat_o;
  logic        spr_sys_mode_i;
  logic        evt_load_i;
  logic        evt_store_i;
  logic        evt_ifetch_i;
  logic        evt_dcache_miss_i;
  logic        evt_icache_miss_i;
  logic        evt_ifetch_stall_i;
  logic        evt_lsu_stall_i;
  logic        evt_brn_stall_i;
  logic        evt_dtlb_miss_i;
  logic        evt_itlb_miss_i;
  logic        evt_datadep_stall_i;

  int checks;
  int errors;

  pcu_top #(
    .NUM_COUNTERS (NUM_SLOTS)
  ) u_dut (
    .clk                 (clk),
    .rst                 (rst),
    .spr_access_i        (spr_access_i),
    .spr_we_i            (spr_we_i),
    .spr_re_i            (spr_re_i),
    .spr_addr_i          (spr_addr_i),
    .spr_dat_i           (spr_dat_i),
    .spr_ack_o           (spr_ack_o),
    .spr_dat_o           (spr_dat_o),
    .spr_sys_mode_i      (spr_sys_mode_i),
    .evt_load_i          (evt_load_i),
    .evt_store_i         (evt_store_i),
    .evt_ifetch_i        (evt_ifetch_i),
    .evt_dcache_miss_i   (evt_dcache_miss_i),
    .evt_icache_miss_i   (evt_icache_miss_i),
    .evt_ifetch_stall_i  (evt_ifetch_stall_i),
    .evt_lsu_stall_i     (evt_lsu_stall_i),
    .evt_brn_stall_i     (evt_brn_stall_i),
    .evt_dtlb_miss_i     (evt_dtlb_miss_i),
    .evt_itlb_miss_i     (evt_itlb_miss_i),
    .evt_datadep_stall_i (evt_datadep_stall_i)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic check_outputs(input logic exp_ack, input logic [31:0] exp_dat);
    checks++;
    assert (spr_ack_o === exp_ack) else begin
      errors++;
      $display("error: spr_ack_o expected %h got %h at %0t", exp_ack, spr_ack_o, $time);
    end
    assert (spr_dat_o === exp_dat) else begin
      errors++;
      $display("error: spr_dat_o expected %h got %h at %0t", exp_dat, spr_dat_o, $time);
    end
  endtask

  `include "pcu_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : watchdog
    while ($time < WATCHDOG_NS) begin
      #100;
    end
    abort_run("timeout: the run did not reach its end in time");
  end

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [10:0] ev;
    logic        sys;
    rst            = 1'b1;
    spr_access_i   = 1'b0;
    spr_we_i       = 1'b0;
    spr_re_i       = 1'b0;
    spr_addr_i     = 16'h0;
    spr_dat_i      = 32'h0;
    spr_sys_mode_i = 1'b1;
    drive_events(11'h0);
    checks    = 0;
    errors    = 0;
    lcg_state = 32'd63982;
    for (int i = 0; i < pcu_pkg::MAX_COUNTERS; i++) begin
      exp_pccr[i] = 32'h0;
      exp_pcmr[i] = pcu_pkg::PCMR_RESET;
    end
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
    end
    @(negedge clk);
    rst = 1'b0;

    // Reset values, absent slots included
    for (int i = 0; i < pcu_pkg::MAX_COUNTERS; i++) begin
      spr_read(pccr_addr(i), 1'b1);
      spr_read(pcmr_addr(i), 1'b1);
    end
    // Other groups and a missing strobe get no ack
    spr_read(16'h3000, 1'b1);
    spr_read(16'h4000, 1'b1);
    spr_write(16'h0000, 32'hDEAD_BEEF, 1'b1);
    run_cycle(1'b0, 1'b0, 1'b1, pccr_addr(0), 32'h0, 1'b1, 11'h0);
    spr_read(16'h3800 | 16'd16, 1'b1);
    spr_read(16'h3FFF, 1'b1);

    // Supervisor writes and readback
    for (int i = 0; i < NUM_SLOTS; i++) begin
      spr_write(pccr_addr(i), lcg_next(), 1'b1);
      spr_write(pcmr_addr(i), lcg_next(), 1'b1);
    end
    for (int i = 0; i < NUM_SLOTS; i++) begin
      spr_read(pccr_addr(i), 1'b1);
      spr_read(pcmr_addr(i), 1'b1);
    end
    // User mode cannot write, and sees PCCR only
    for (int i = 0; i < NUM_SLOTS; i++) begin
      spr_write(pccr_addr(i), 32'h0BAD_0000 + 32'(i), 1'b0);
      spr_write(pcmr_addr(i), 32'h0000_3FFE, 1'b0);
      spr_read(pccr_addr(i), 1'b0);
      spr_read(pcmr_addr(i), 1'b0);
      spr_read(pcmr_addr(i), 1'b1);
    end

    // Privilege gating with load events only
    for (int i = 0; i < NUM_SLOTS; i++) begin
      spr_write(pcmr_addr(i), 32'h0, 1'b1);
    end
    spr_write(pcmr_addr(0), 32'h0000_000A, 1'b1);
    spr_write(pcmr_addr(1), 32'h0000_000C, 1'b1);
    spr_write(pccr_addr(0), 32'h0, 1'b1);
    spr_write(pccr_addr(1), 32'h0, 1'b1);
    repeat (10) idle_cycle(1'b1, 11'h001);
    repeat (7) idle_cycle(1'b0, 11'h001);
    // Store is not enabled on either slot
    repeat (3) idle_cycle(1'b1, 11'h002);
    spr_read(pccr_addr(0), 1'b1);
    spr_read(pccr_addr(1), 1'b1);

    // Random masks and events on all built slots
    for (int r = 0; r < RANDOM_ROUNDS; r++) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        rnd  = lcg_next();
        rnd2 = lcg_next();
        spr_write(pcmr_addr(i), {rnd[31:16], rnd2[31:16]}, 1'b1);
        spr_write(pccr_addr(i), lcg_next(), 1'b1);
      end
      for (int c = 0; c < ROUND_CYCLES; c++) begin
        rnd = lcg_next();
        ev  = rnd[26:16];
        sys = rnd[31];
        if (c % 20 == 19) begin
          run_cycle(1'b1, 1'b0, 1'b1, pccr_addr((c / 20) % NUM_SLOTS), 32'h0, sys, ev);
        end else begin
          idle_cycle(sys, ev);
        end
      end
      for (int i = 0; i < NUM_SLOTS; i++) begin
        spr_read(pccr_addr(i), 1'b1);
        spr_read(pcmr_addr(i), 1'b1);
      end
    end

    // Wrap through zero on slot 2, all events enabled
    spr_write(pcmr_addr(2), 32'h0000_3FFA, 1'b1);
    spr_write(pccr_addr(2), 32'hFFFF_FFFE, 1'b1);
    spr_read(pccr_addr(2), 1'b1);
    idle_cycle(1'b1, 11'h001);
    spr_read(pccr_addr(2), 1'b1);
    idle_cycle(1'b1, 11'h003);
    spr_read(pccr_addr(2), 1'b1);
    idle_cycle(1'b1, 11'h7FF);
    spr_read(pccr_addr(2), 1'b1);
    // Write beats the increment of the same cycle
    run_cycle(1'b1, 1'b1, 1'b0, pccr_addr(2), 32'h0000_1234, 1'b1, 11'h7FF);
    spr_read(pccr_addr(2), 1'b1);

    // Absent slots and unused offsets
    for (int i = NUM_SLOTS; i < pcu_pkg::MAX_COUNTERS; i++) begin
      spr_write(pccr_addr(i), 32'h1111_1111, 1'b1);
      spr_write(pcmr_addr(i), 32'h0000_3FFE, 1'b1);
      spr_read(pccr_addr(i), 1'b1);
      spr_read(pcmr_addr(i), 1'b1);
    end
    spr_write(16'h3800 | 16'd16, 32'h2222_2222, 1'b1);
    spr_write(16'h3FFF, 32'h3333_3333, 1'b1);
    spr_read(16'h3800 | 16'd16, 1'b1);
    spr_read(16'h3FFF, 1'b1);
    for (int i = 0; i < NUM_SLOTS; i++) begin
      spr_read(pccr_addr(i), 1'b1);
      spr_read(pcmr_addr(i), 1'b1);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
source/pcu_pkg.sv
source/pcu_event_count.sv
source/pcu_counter_slot.sv
source/pcu_spr_port.sv
source/pcu_top.sv
+incdir+tb
tb/pcu_tb.sv
